// ==== hw/hdc_pkg.sv ====
package hdc_pkg;

    // hypervector geometry
    localparam int DIM_BITS       = 128;
    localparam int WORD_BITS      = 32;
    localparam int WORDS_PER_VEC  = DIM_BITS / WORD_BITS;
    localparam int WORD_IDX_BITS  = $clog2(WORDS_PER_VEC);

    // item memory
    localparam int ITEM_DEPTH     = 16;
    localparam int ITEM_ADDR_BITS = $clog2(ITEM_DEPTH);

    // barrel threading
    localparam int THREADS        = 4;
    localparam int THREAD_BITS    = $clog2(THREADS);

    // instruction word
    localparam int SHIFT_BITS     = 7;
    localparam int INSTR_BITS     = 16;

    // opcode flag count in the operate form (is_load, permute, bind, store, hold)
    localparam int OP_FLAG_BITS   = 5;

    // unused gaps between the opcode bits and the operand field
    localparam int LOAD_PAD_BITS  = INSTR_BITS - 1 - ITEM_ADDR_BITS;
    localparam int OP_PAD_BITS    = INSTR_BITS - OP_FLAG_BITS - SHIFT_BITS;

    typedef logic [DIM_BITS-1:0] vec_t;

    // bit 15 selects which view applies
    typedef union packed {
        struct packed {
            logic                      is_load;
            logic [LOAD_PAD_BITS-1:0]  unused;
            logic [ITEM_ADDR_BITS-1:0] item_addr;
        } load_form;
        struct packed {
            logic                      is_load;
            logic                      permute;
            logic                      bind_op;
            logic                      store;
            logic                      hold;
            logic [OP_PAD_BITS-1:0]    unused;
            logic [SHIFT_BITS-1:0]     shift;
        } op_form;
    } instr_t;

endpackage

// ==== hw/hdc_item_memory.sv ====
`timescale 1ns/1ps

module hdc_item_memory (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                load_mode,
    input  logic                                word_valid,
    input  logic [hdc_pkg::WORD_BITS-1:0]       word_data,
    input  logic [hdc_pkg::ITEM_ADDR_BITS-1:0]  rd_addr,
    output hdc_pkg::vec_t                       rd_vector
);

    logic [hdc_pkg::WORD_IDX_BITS-1:0]  word_idx;
    logic [hdc_pkg::ITEM_ADDR_BITS-1:0] wr_addr;
    logic                               wr_en;
    logic                               word_take;
    logic                               last_word;
    hdc_pkg::vec_t                      staging;
    hdc_pkg::vec_t                      item_mem [hdc_pkg::ITEM_DEPTH];

    assign word_take = load_mode & word_valid;
    assign last_word = (word_idx == hdc_pkg::WORD_IDX_BITS'(hdc_pkg::WORDS_PER_VEC - 1));

    // word counter, wraps after the top slice
    always_ff @(posedge clk) begin
        if (rst || !load_mode) begin
            word_idx <= '0;
        end else if (word_valid) begin
            word_idx <= word_idx + 1'b1;
        end
    end

    // first word lands in the low slice
    always_ff @(posedge clk) begin
        if (word_take) begin
            staging[word_idx*hdc_pkg::WORD_BITS +: hdc_pkg::WORD_BITS] <= word_data;
        end
    end

    // write strobe one edge after the fourth word
    always_ff @(posedge clk) begin
        if (rst) begin
            wr_en <= 1'b0;
        end else begin
            wr_en <= word_take & last_word;
        end
    end

    // next free entry, restarts with every load session
    always_ff @(posedge clk) begin
        if (rst || !load_mode) begin
            wr_addr <= '0;
        end else if (wr_en) begin
            wr_addr <= wr_addr + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < hdc_pkg::ITEM_DEPTH; i++) begin
                item_mem[i] <= '0;
            end
        end else if (wr_en) begin
            item_mem[wr_addr] <= staging;
        end
    end

    // free-running registered read
    always_ff @(posedge clk) begin
        rd_vector <= item_mem[rd_addr];
    end

endmodule

// ==== hw/hdc_decode.sv ====
`timescale 1ns/1ps

module hdc_decode (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                run,
    input  logic                                instr_valid,
    input  hdc_pkg::instr_t                     instr,
    output logic [hdc_pkg::ITEM_ADDR_BITS-1:0]  item_addr,
    output logic                                op_valid,
    output logic [hdc_pkg::THREAD_BITS-1:0]     op_thread,
    output logic                                op_load,
    output logic                                op_permute,
    output logic                                op_bind,
    output logic                                op_hold,
    output logic                                op_store,
    output logic [hdc_pkg::SHIFT_BITS-1:0]      op_shift
);

    logic                               accept;
    logic                               valid_q;
    logic                               is_load;
    logic [hdc_pkg::THREAD_BITS-1:0]    thread_cnt;
    hdc_pkg::instr_t                    instr_q;

    assign accept = run & instr_valid;

    // item read starts with the raw word so its data meets the decoded op
    assign item_addr = instr.load_form.item_addr;

    always_ff @(posedge clk) begin
        if (accept) begin
            instr_q <= instr;
        end
    end

    // thread rotation, back to thread 0 whenever run drops
    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q    <= 1'b0;
            thread_cnt <= '0;
            op_thread  <= '0;
        end else if (!run) begin
            valid_q    <= 1'b0;
            thread_cnt <= '0;
        end else begin
            valid_q <= instr_valid;
            if (instr_valid) begin
                op_thread  <= thread_cnt;
                thread_cnt <= thread_cnt + 1'b1;
            end
        end
    end

    // an op still in decode is dropped when run falls
    assign op_valid = valid_q & run;

    // flags of the other form read as zero
    assign is_load    = instr_q.load_form.is_load;
    assign op_load    = is_load;
    assign op_permute = !is_load & instr_q.op_form.permute;
    assign op_bind    = !is_load & instr_q.op_form.bind_op;
    assign op_hold    = !is_load & instr_q.op_form.hold;
    assign op_store   = !is_load & instr_q.op_form.store;
    assign op_shift   = is_load ? '0 : instr_q.op_form.shift;

endmodule

// ==== hw/hdc_execute.sv ====
`timescale 1ns/1ps

module hdc_execute (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                op_valid,
    input  logic [hdc_pkg::THREAD_BITS-1:0]     op_thread,
    input  logic                                op_load,
    input  logic                                op_permute,
    input  logic                                op_bind,
    input  logic                                op_hold,
    input  logic                                op_store,
    input  logic [hdc_pkg::SHIFT_BITS-1:0]      op_shift,
    input  hdc_pkg::vec_t                       item_vector,
    output logic                                result_valid,
    output hdc_pkg::vec_t                       result
);

    // per-thread state
    hdc_pkg::vec_t acc  [hdc_pkg::THREADS];
    hdc_pkg::vec_t hold [hdc_pkg::THREADS];

    hdc_pkg::vec_t                      acc_cur;
    hdc_pkg::vec_t                      hold_cur;
    hdc_pkg::vec_t                      rotated;
    hdc_pkg::vec_t                      operand;
    hdc_pkg::vec_t                      bound;
    logic [2*hdc_pkg::DIM_BITS-1:0]     doubled;
    logic                               do_load;
    logic                               do_bind;
    logic                               do_hold;
    logic                               do_store;

    assign acc_cur  = acc[op_thread];
    assign hold_cur = hold[op_thread];

    // left rotate, bit i moves to (i + shift) mod DIM
    // upper half of the shifted double copy is the rotated vector
    assign doubled = {acc_cur, acc_cur} << op_shift;
    assign rotated = doubled[2*hdc_pkg::DIM_BITS-1 -: hdc_pkg::DIM_BITS];

    assign operand = op_permute ? rotated : acc_cur;
    assign bound   = hold_cur ^ operand;

    assign do_load  = op_valid & op_load;
    assign do_bind  = op_valid & op_bind;
    assign do_hold  = op_valid & op_hold;
    assign do_store = op_valid & op_store;

    // accumulator update
    // load and bind come from different forms, never together
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int t = 0; t < hdc_pkg::THREADS; t++) begin
                acc[t] <= '0;
            end
        end else if (do_load) begin
            acc[op_thread] <= item_vector;
        end else if (do_bind) begin
            acc[op_thread] <= bound;
        end
    end

    // hold takes the pre-bind operand, even alongside bind
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int t = 0; t < hdc_pkg::THREADS; t++) begin
                hold[t] <= '0;
            end
        end else if (do_hold) begin
            hold[op_thread] <= operand;
        end
    end

    // output register, zero unless a store fires
    always_ff @(posedge clk) begin
        if (rst) begin
            result_valid <= 1'b0;
            result       <= '0;
        end else begin
            result_valid <= do_store;
            result       <= do_store ? operand : '0;
        end
    end

endmodule

// ==== hw/hdc_core.sv ====
`timescale 1ns/1ps

module hdc_core (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            run,
    input  logic                            load_mode,
    input  logic                            word_valid,
    input  logic [hdc_pkg::WORD_BITS-1:0]   word_data,
    input  logic                            instr_valid,
    input  hdc_pkg::instr_t                 instr,
    output logic                            result_valid,
    output hdc_pkg::vec_t                   result
);

    // decode to item memory
    logic [hdc_pkg::ITEM_ADDR_BITS-1:0] item_addr;

    // decode to execute
    logic                               op_valid;
    logic [hdc_pkg::THREAD_BITS-1:0]    op_thread;
    logic                               op_load;
    logic                               op_permute;
    logic                               op_bind;
    logic                               op_hold;
    logic                               op_store;
    logic [hdc_pkg::SHIFT_BITS-1:0]     op_shift;

    // item memory to execute, lines up with the decode stage
    hdc_pkg::vec_t                      item_vector;

    hdc_item_memory i_item_memory (
        .clk        (clk),
        .rst        (rst),
        .load_mode  (load_mode),
        .word_valid (word_valid),
        .word_data  (word_data),
        .rd_addr    (item_addr),
        .rd_vector  (item_vector)
    );

    hdc_decode i_decode (
        .clk         (clk),
        .rst         (rst),
        .run         (run),
        .instr_valid (instr_valid),
        .instr       (instr),
        .item_addr   (item_addr),
        .op_valid    (op_valid),
        .op_thread   (op_thread),
        .op_load     (op_load),
        .op_permute  (op_permute),
        .op_bind     (op_bind),
        .op_hold     (op_hold),
        .op_store    (op_store),
        .op_shift    (op_shift)
    );

    hdc_execute i_execute (
        .clk          (clk),
        .rst          (rst),
        .op_valid     (op_valid),
        .op_thread    (op_thread),
        .op_load      (op_load),
        .op_permute   (op_permute),
        .op_bind      (op_bind),
        .op_hold      (op_hold),
        .op_store     (op_store),
        .op_shift     (op_shift),
        .item_vector  (item_vector),
        .result_valid (result_valid),
        .result       (result)
    );

endmodule

// ==== dv/hdc_core_assertions.sv ====
`timescale 1ns/1ps

module hdc_core_assertions (
    input logic          clk,
    input logic          rst,
    input logic          run,
    input logic          instr_valid,
    input logic          result_valid,
    input hdc_pkg::vec_t result
);

    int failures;

    initial begin
        failures = 0;
    end

    // output register stays cleared between stores
    idle_result_zero: assert property (
        @(posedge clk) disable iff (rst) !result_valid |-> (result == '0)
    ) else begin
        $error("result is nonzero while result_valid is low");
        failures++;
    end

    // two-stage pipe from strobe to result
    result_has_source: assert property (
        @(posedge clk) disable iff (rst) result_valid |-> $past(instr_valid, 2)
    ) else begin
        $error("result_valid without instr_valid two cycles earlier");
        failures++;
    end

    // ops in flight are dropped with run
    no_result_after_stop: assert property (
        @(posedge clk) disable iff (rst) !run |=> !result_valid
    ) else begin
        $error("result_valid high one cycle after run was low");
        failures++;
    end

endmodule

bind hdc_core hdc_core_assertions i_hdc_core_assertions (
    .clk          (clk),
    .rst          (rst),
    .run          (run),
    .instr_valid  (instr_valid),
    .result_valid (result_valid),
    .result       (result)
);

// ==== dv/hdc_core_tb.sv ====
`timescale 1ns/1ps

module hdc_core_tb;

    logic                           clk;
    logic                           rst;
    logic                           run;
    logic                           load_mode;
    logic                           word_valid;
    logic [hdc_pkg::WORD_BITS-1:0]  word_data;
    logic                           instr_valid;
    hdc_pkg::instr_t                instr;
    logic                           result_valid;
    hdc_pkg::vec_t                  result;

    // reference copies of item memory and per-thread registers
    hdc_pkg::vec_t  item_m [hdc_pkg::ITEM_DEPTH];
    hdc_pkg::vec_t  acc_m  [hdc_pkg::THREADS];
    hdc_pkg::vec_t  hold_m [hdc_pkg::THREADS];
    logic [1:0]     thread_m;
    logic [31:0]    rng;

    // stimulus table: instruction word, run level, store expected
    logic [15:0]    tab_instr [$];
    logic           tab_run   [$];
    logic           tab_store [$];

    // expected outputs, one per applied entry
    logic           exp_valid  [$];
    hdc_pkg::vec_t  exp_result [$];

    int errors;
    int checks;

    hdc_core i_hdc_core (
        .clk          (clk),
        .rst          (rst),
        .run          (run),
        .load_mode    (load_mode),
        .word_valid   (word_valid),
        .word_data    (word_data),
        .instr_valid  (instr_valid),
        .instr        (instr),
        .result_valid (result_valid),
        .result       (result)
    );

    always #5 clk = ~clk;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // bit i ends up at (i + s) mod 128
    function automatic hdc_pkg::vec_t rotate_left(input hdc_pkg::vec_t v, input logic [6:0] s);
        return (v << s) | (v >> (hdc_pkg::DIM_BITS - int'(s)));
    endfunction

    function automatic logic [15:0] load_instr(input int addr);
        return {1'b1, 11'd0, 4'(addr)};
    endfunction

    function automatic logic [15:0] op_instr(input int permute, input int bind_op,
                                             input int store, input int hold, input int shift);
        return {1'b0, permute[0], bind_op[0], store[0], hold[0], 4'd0, 7'(shift)};
    endfunction

    task automatic add_entry(input logic [15:0] w, input logic r, input logic st);
        tab_instr.push_back(w);
        tab_run.push_back(r);
        tab_store.push_back(st);
    endtask

    // same word on each thread in issue order
    task automatic add_round(input logic [15:0] w, input logic st);
        for (int t = 0; t < hdc_pkg::THREADS; t++) begin
            add_entry(w, 1'b1, st);
        end
    endtask

    task automatic add_loads(input int base);
        for (int t = 0; t < hdc_pkg::THREADS; t++) begin
            add_entry(load_instr(base + t), 1'b1, 1'b0);
        end
    endtask

    task automatic build_table();
        int shifts [8] = '{0, 1, 127, 64, 5, 63, 100, 126};
        // every item address, loaded then stored
        for (int a = 0; a < hdc_pkg::ITEM_DEPTH; a += 4) begin
            add_loads(a);
            add_round(op_instr(0, 0, 1, 0, 0), 1'b1);
        end
        // permuted stores
        add_loads(0);
        for (int s = 0; s < 8; s++) begin
            add_entry(op_instr(1, 0, 1, 0, shifts[s]), 1'b1, 1'b1);
        end
        // hold, reload, bind, store
        add_round(op_instr(0, 0, 0, 1, 0), 1'b0);
        add_loads(8);
        add_round(op_instr(0, 1, 0, 0, 0), 1'b0);
        add_round(op_instr(0, 0, 1, 0, 0), 1'b1);
        // permute, bind, hold and store in one op
        for (int t = 0; t < hdc_pkg::THREADS; t++) begin
            add_entry(op_instr(1, 1, 1, 1, shifts[t + 4]), 1'b1, 1'b1);
        end
        add_round(op_instr(0, 0, 1, 0, 0), 1'b1);
        // back-to-back chains across all threads
        add_loads(12);
        add_round(op_instr(1, 1, 0, 0, 3), 1'b0);
        add_round(op_instr(0, 1, 0, 1, 0), 1'b0);
        add_round(op_instr(0, 0, 1, 0, 0), 1'b1);
        // pending bind and store dropped with run, ignored ops, then restart at thread 0
        add_entry(op_instr(0, 1, 1, 0, 0), 1'b1, 1'b0);
        add_entry(op_instr(0, 0, 1, 0, 0), 1'b0, 1'b0);
        add_entry(load_instr(5), 1'b0, 1'b0);
        add_round(op_instr(0, 0, 1, 0, 0), 1'b1);
    endtask

    // applies one entry to the model, r_next is run during its execute cycle
    task automatic model_step(input logic [15:0] w, input logic r, input logic r_next,
                              input logic st);
        hdc_pkg::vec_t operand;
        hdc_pkg::vec_t expv;
        logic [1:0]    t;
        expv = '0;
        t    = thread_m;
        if (!r) begin
            thread_m = 2'd0;
        end else begin
            thread_m = thread_m + 2'd1;
            if (r_next && w[15]) begin
                acc_m[t] = item_m[w[3:0]];
            end else if (r_next) begin
                operand = w[14] ? rotate_left(acc_m[t], w[6:0]) : acc_m[t];
                if (w[13]) begin
                    acc_m[t] = hold_m[t] ^ operand;
                end
                if (w[11]) begin
                    hold_m[t] = operand;
                end
                if (w[12]) begin
                    expv = operand;
                end
            end
        end
        exp_valid.push_back(st);
        exp_result.push_back(expv);
    endtask

    task automatic check_outputs(input logic ev, input hdc_pkg::vec_t er);
        checks++;
        assert (result_valid === ev)
            else begin
                errors++;
                $display("[ERROR] result_valid: got %h, expected %h", result_valid, ev);
            end
        assert (result === er)
            else begin
                errors++;
                $display("[ERROR] result: got %h, expected %h", result, er);
            end
    endtask

    initial begin
        int n;
        int timeout;
        int bound_fails;
        clk         = 1'b0;
        rst         = 1'b1;
        run         = 1'b0;
        load_mode   = 1'b0;
        word_valid  = 1'b0;
        word_data   = '0;
        instr_valid = 1'b0;
        instr       = '0;
        errors      = 0;
        checks      = 0;
        rng         = 32'd22812;
        thread_m    = 2'd0;
        for (int t = 0; t < hdc_pkg::THREADS; t++) begin
            acc_m[t]  = '0;
            hold_m[t] = '0;
        end
        build_table();

        repeat (4) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        check_outputs(1'b0, '0);

        // words in order, each new word shifted in from the top
        for (int a = 0; a < hdc_pkg::ITEM_DEPTH; a++) begin
            for (int w = 0; w < hdc_pkg::WORDS_PER_VEC; w++) begin
                rng       = xorshift32(rng);
                item_m[a] = {rng, item_m[a][hdc_pkg::DIM_BITS-1:hdc_pkg::WORD_BITS]};
                @(posedge clk);
                load_mode  <= 1'b1;
                word_valid <= 1'b1;
                word_data  <= rng;
            end
        end
        @(posedge clk);
        word_valid <= 1'b0;
        @(posedge clk);
        load_mode <= 1'b0;

        // results of entry i are checked two cycles after it is applied
        n = tab_instr.size();
        for (int i = 0; i < n + 2; i++) begin
            @(posedge clk);
            if (i < n) begin
                instr       <= tab_instr[i];
                run         <= tab_run[i];
                instr_valid <= 1'b1;
                model_step(tab_instr[i], tab_run[i], (i + 1 < n) ? tab_run[i + 1] : 1'b1,
                           tab_store[i]);
            end else begin
                instr_valid <= 1'b0;
            end
            @(negedge clk);
            if (i >= 2) begin
                check_outputs(exp_valid.pop_front(), exp_result.pop_front());
            end else begin
                check_outputs(1'b0, '0);
            end
        end

        timeout = 0;
        while (result_valid !== 1'b0 && timeout < 10) begin
            @(negedge clk);
            timeout++;
        end
        if (result_valid !== 1'b0) begin
            errors++;
            $display("timed out waiting for result_valid to go low after the last entry");
        end

        bound_fails = i_hdc_core.i_hdc_core_assertions.failures;
        $display("checks %0d, errors %0d, assertion failures %0d",
                 checks, errors, bound_fails);
        if (errors == 0 && bound_fails == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

// ==== build.f ====
hw/hdc_pkg.sv
hw/hdc_item_memory.sv
hw/hdc_decode.sv
hw/hdc_execute.sv
hw/hdc_core.sv
dv/hdc_core_assertions.sv
dv/hdc_core_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --assert -j 0
TOP       := hdc_core_tb
FILELIST  := build.f
OBJ_DIR   := obj_dir

SIM_BIN   := $(OBJ_DIR)/V$(TOP)
SOURCES   := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: $(SIM_BIN)

# rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	@out="$$(./$(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^Result: PASSED$$"

clean:
	rm -rf $(OBJ_DIR)
